//--- design/gcm_tag_pkg.sv
package gcm_tag_pkg;

    // Block width shared by J0 tags, GHASH values and output tags
    localparam int BLOCK_BITS     = 128;

    // Tag queue depth, also the upstream credit pool after reset
    localparam int TAG_FIFO_DEPTH = 4;

    // Count and credit counters must hold 0..TAG_FIFO_DEPTH
    localparam int TAG_CNT_BITS   = 3;

    // Queue read and write pointer width
    localparam int TAG_PTR_BITS   = $clog2(TAG_FIFO_DEPTH);

    typedef logic [BLOCK_BITS-1:0] tag_block_t;

    // Upstream command opcodes
    typedef enum logic [2:0]
    {
        CMD_NOP           = 3'd0,
        CMD_UPDATE_KEY    = 3'd1,
        CMD_HPOW_CALC     = 3'd2,   // Data carries the new J0
        CMD_SOP_PRE       = 3'd3,   // Data carries the normal J0
        CMD_TRIG_SOP_PRE  = 3'd4,
        CMD_KEY_LOAD_DONE = 3'd5,
        CMD_LOCK_NEW      = 3'd6,
        CMD_TAG_FINAL     = 3'd7    // Data carries the GHASH result
    } cmd_op_e;

    // J0 tag lock states
    typedef enum logic [2:0]
    {
        ST_WAIT_KEY_UPDATE      = 3'd0,
        ST_WAIT_TRIG_SOP_FIRST  = 3'd1,
        ST_WAIT_TRIG_SOP_SECOND = 3'd2,
        ST_WAIT_KEY_SWITCH_DONE = 3'd3,
        ST_WAIT_LOCK_TRIGGER    = 3'd4
    } lock_state_e;

endpackage

//--- design/gcm_cmd_decoder.sv
`timescale 1ns/10ps

module gcm_cmd_decoder
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_cmd_valid,
    input  gcm_tag_pkg::cmd_op_e    i_cmd_op,
    input  gcm_tag_pkg::tag_block_t i_cmd_data,
    output logic                    o_update_key,
    output logic                    o_hpow_calc,
    output logic                    o_sop_pre,
    output logic                    o_trig_sop_pre,
    output logic                    o_key_load_done,
    output logic                    o_lock_new,
    output logic                    o_tag_final,
    output gcm_tag_pkg::tag_block_t o_data
);

    import gcm_tag_pkg::*;

    // One-hot strobes, live for a single cycle per command
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_update_key    <= 1'b0;
            o_hpow_calc     <= 1'b0;
            o_sop_pre       <= 1'b0;
            o_trig_sop_pre  <= 1'b0;
            o_key_load_done <= 1'b0;
            o_lock_new      <= 1'b0;
            o_tag_final     <= 1'b0;
        end
        else
        begin
            o_update_key    <= 1'b0;    // Cleared unless a new command lands
            o_hpow_calc     <= 1'b0;
            o_sop_pre       <= 1'b0;
            o_trig_sop_pre  <= 1'b0;
            o_key_load_done <= 1'b0;
            o_lock_new      <= 1'b0;
            o_tag_final     <= 1'b0;
            if (i_cmd_valid)
            begin
                case (i_cmd_op)
                    CMD_UPDATE_KEY:    o_update_key    <= 1'b1;
                    CMD_HPOW_CALC:     o_hpow_calc     <= 1'b1;
                    CMD_SOP_PRE:       o_sop_pre       <= 1'b1;
                    CMD_TRIG_SOP_PRE:  o_trig_sop_pre  <= 1'b1;
                    CMD_KEY_LOAD_DONE: o_key_load_done <= 1'b1;
                    CMD_LOCK_NEW:      o_lock_new      <= 1'b1;
                    CMD_TAG_FINAL:     o_tag_final     <= 1'b1;
                    default:
                    begin
                        // NOP raises nothing
                    end
                endcase
            end
        end
    end

    // Payload follows the strobes into the same cycle
    always_ff @(posedge i_clock)
    begin
        if (i_cmd_valid)
        begin
            o_data <= i_cmd_data;
        end
    end

endmodule

//--- design/j0_tag_fsm.sv
`timescale 1ns/10ps

module j0_tag_fsm
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_update_key,
    input  logic                    i_hpow_calc,
    input  logic                    i_sop_pre,
    input  logic                    i_trig_sop_pre,
    input  logic                    i_key_load_done,
    input  logic                    i_lock_new,
    input  gcm_tag_pkg::tag_block_t i_j0_tag,
    output gcm_tag_pkg::tag_block_t o_j0_tag_locked
);

    import gcm_tag_pkg::*;

    lock_state_e state;
    lock_state_e state_next;

    tag_block_t  j0_old_reg;
    tag_block_t  j0_new_reg;
    tag_block_t  j0_normal_reg;
    tag_block_t  j0_old;
    tag_block_t  j0_new;
    tag_block_t  j0_normal;
    tag_block_t  j0_locked;

    // H-power calc shifts new into old, normal J0 comes with each SOP
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            j0_old_reg    <= '0;
            j0_new_reg    <= '0;
            j0_normal_reg <= '0;
        end
        else
        begin
            if (i_hpow_calc)
            begin
                j0_old_reg <= j0_new_reg;
                j0_new_reg <= i_j0_tag;
            end
            if (i_sop_pre)
            begin
                j0_normal_reg <= i_j0_tag;
            end
        end
    end

    // Bypass so a tag written this cycle is usable right away
    assign j0_new    = i_hpow_calc ? i_j0_tag   : j0_new_reg;
    assign j0_old    = i_hpow_calc ? j0_new_reg : j0_old_reg;
    assign j0_normal = i_sop_pre   ? i_j0_tag   : j0_normal_reg;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state <= ST_WAIT_KEY_UPDATE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        j0_locked  = j0_normal;
        case (state)
            ST_WAIT_KEY_UPDATE:
            begin
                j0_locked = j0_normal;
            end
            ST_WAIT_TRIG_SOP_FIRST:
            begin
                if (i_trig_sop_pre)
                begin
                    state_next = ST_WAIT_TRIG_SOP_SECOND;
                end
                j0_locked = i_trig_sop_pre ? j0_old : j0_normal;   // First SOP still on old key
            end
            ST_WAIT_TRIG_SOP_SECOND:
            begin
                if (i_trig_sop_pre)
                begin
                    state_next = ST_WAIT_KEY_SWITCH_DONE;
                end
                j0_locked = j0_normal;
            end
            ST_WAIT_KEY_SWITCH_DONE:
            begin
                if (i_key_load_done)
                begin
                    state_next = ST_WAIT_LOCK_TRIGGER;
                end
                j0_locked = i_key_load_done ? j0_new : j0_old;
            end
            ST_WAIT_LOCK_TRIGGER:
            begin
                if (i_lock_new)
                begin
                    state_next = ST_WAIT_KEY_UPDATE;
                end
                j0_locked = j0_new;
            end
            default:
            begin
                state_next = ST_WAIT_KEY_UPDATE;    // Recover from illegal encodings
                j0_locked  = j0_normal;
            end
        endcase
        // Key update restarts the switch from any state
        if (i_update_key)
        begin
            state_next = ST_WAIT_TRIG_SOP_FIRST;
        end
    end

    assign o_j0_tag_locked = j0_locked;

endmodule

//--- design/gcm_tag_finalizer.sv
`timescale 1ns/10ps

module gcm_tag_finalizer
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_tag_final,
    input  gcm_tag_pkg::tag_block_t i_ghash,
    input  gcm_tag_pkg::tag_block_t i_j0_tag_locked,
    input  logic                    i_tag_credit,
    output logic                    o_tag_valid,
    output gcm_tag_pkg::tag_block_t o_tag,
    output logic                    o_cmd_credit
);

    import gcm_tag_pkg::*;

    tag_block_t              tag_mem [0:TAG_FIFO_DEPTH-1];
    logic [TAG_PTR_BITS-1:0] wr_ptr;
    logic [TAG_PTR_BITS-1:0] rd_ptr;
    logic [TAG_CNT_BITS-1:0] count;
    logic [TAG_CNT_BITS-1:0] dn_credit;    // Downstream credits on hand
    logic                    push;
    logic                    pop;

    assign push = i_tag_final;     // Upstream credits guarantee room
    assign pop  = (count != '0) && (dn_credit != '0);

    // Masked tag storage
    always_ff @(posedge i_clock)
    begin
        if (push)
        begin
            tag_mem[wr_ptr] <= i_ghash ^ i_j0_tag_locked;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            dn_credit <= TAG_CNT_BITS'(TAG_FIFO_DEPTH);
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;    // Depth is a power of two, wraps naturally
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + TAG_CNT_BITS'(push) - TAG_CNT_BITS'(pop);
            dn_credit <= dn_credit + TAG_CNT_BITS'(i_tag_credit) - TAG_CNT_BITS'(pop);
        end
    end

    // Output stage and upstream credit return
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_tag_valid  <= 1'b0;
            o_cmd_credit <= 1'b0;
        end
        else
        begin
            o_tag_valid  <= pop;
            o_cmd_credit <= pop;    // Slot freed by this pop
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (pop)
        begin
            o_tag <= tag_mem[rd_ptr];
        end
    end

endmodule

//--- design/gcm_tag_unit.sv
`timescale 1ns/10ps

module gcm_tag_unit
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_cmd_valid,
    input  gcm_tag_pkg::cmd_op_e    i_cmd_op,
    input  gcm_tag_pkg::tag_block_t i_cmd_data,
    input  logic                    i_tag_credit,
    output logic                    o_cmd_credit,
    output logic                    o_tag_valid,
    output gcm_tag_pkg::tag_block_t o_tag
);

    import gcm_tag_pkg::*;

    logic       d_update_key;
    logic       d_hpow_calc;
    logic       d_sop_pre;
    logic       d_trig_sop_pre;
    logic       d_key_load_done;
    logic       d_lock_new;
    logic       d_tag_final;
    tag_block_t d_data;         // J0 or GHASH, depending on the strobe
    tag_block_t j0_locked;

    gcm_cmd_decoder u_decoder
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_cmd_valid     (i_cmd_valid),
        .i_cmd_op        (i_cmd_op),
        .i_cmd_data      (i_cmd_data),
        .o_update_key    (d_update_key),
        .o_hpow_calc     (d_hpow_calc),
        .o_sop_pre       (d_sop_pre),
        .o_trig_sop_pre  (d_trig_sop_pre),
        .o_key_load_done (d_key_load_done),
        .o_lock_new      (d_lock_new),
        .o_tag_final     (d_tag_final),
        .o_data          (d_data)
    );

    j0_tag_fsm u_j0_fsm
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_update_key    (d_update_key),
        .i_hpow_calc     (d_hpow_calc),
        .i_sop_pre       (d_sop_pre),
        .i_trig_sop_pre  (d_trig_sop_pre),
        .i_key_load_done (d_key_load_done),
        .i_lock_new      (d_lock_new),
        .i_j0_tag        (d_data),
        .o_j0_tag_locked (j0_locked)
    );

    gcm_tag_finalizer u_finalizer
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_tag_final     (d_tag_final),
        .i_ghash         (d_data),
        .i_j0_tag_locked (j0_locked),
        .i_tag_credit    (i_tag_credit),
        .o_tag_valid     (o_tag_valid),
        .o_tag           (o_tag),
        .o_cmd_credit    (o_cmd_credit)
    );

endmodule

//--- sim/gcm_tag_model.svh
`ifndef GCM_TAG_MODEL_SVH
`define GCM_TAG_MODEL_SVH

// Reference copy of the J0 lock machine, stepped once per command
lock_state_e model_state;
tag_block_t  model_old;
tag_block_t  model_new;
tag_block_t  model_normal;
tag_block_t  exp_tags[$];      // Expected tags in delivery order
int          state_hits[5];    // Final commands seen in each lock state

function automatic void reset_model();
    model_state  = ST_WAIT_KEY_UPDATE;
    model_old    = '0;
    model_new    = '0;
    model_normal = '0;
    exp_tags.delete();
    foreach (state_hits[i])
    begin
        state_hits[i] = 0;
    end
endfunction

// Only one strobe per cycle, so a final command never sees trig or load-done high
function automatic tag_block_t locked_j0();
    tag_block_t j0;
    case (model_state)
        ST_WAIT_KEY_SWITCH_DONE: j0 = model_old;
        ST_WAIT_LOCK_TRIGGER:    j0 = model_new;
        default:                 j0 = model_normal;
    endcase
    return j0;
endfunction

task automatic apply_command(input cmd_op_e op, input tag_block_t data);
    case (op)
        CMD_UPDATE_KEY: model_state = ST_WAIT_TRIG_SOP_FIRST;   // From any state
        CMD_HPOW_CALC:
        begin
            model_old = model_new;
            model_new = data;
        end
        CMD_SOP_PRE: model_normal = data;
        CMD_TRIG_SOP_PRE:
        begin
            if (model_state == ST_WAIT_TRIG_SOP_FIRST)
            begin
                model_state = ST_WAIT_TRIG_SOP_SECOND;
            end
            else if (model_state == ST_WAIT_TRIG_SOP_SECOND)
            begin
                model_state = ST_WAIT_KEY_SWITCH_DONE;
            end
        end
        CMD_KEY_LOAD_DONE:
        begin
            if (model_state == ST_WAIT_KEY_SWITCH_DONE)
            begin
                model_state = ST_WAIT_LOCK_TRIGGER;
            end
        end
        CMD_LOCK_NEW:
        begin
            if (model_state == ST_WAIT_LOCK_TRIGGER)
            begin
                model_state = ST_WAIT_KEY_UPDATE;
            end
        end
        CMD_TAG_FINAL:
        begin
            state_hits[model_state]++;
            exp_tags.push_back(data ^ locked_j0());
        end
        default:
        begin
            // NOP leaves the model alone
        end
    endcase
endtask

function automatic logic states_covered();
    logic all_hit;
    all_hit = 1'b1;
    foreach (state_hits[i])
    begin
        if (state_hits[i] == 0)
        begin
            all_hit = 1'b0;
        end
    end
    return all_hit;
endfunction

task automatic check_tag(input tag_block_t actual, input tag_block_t expected, input string what);
    if (actual !== expected)
    begin
        $display("CHECK FAILED at %0t ns: %s, expected %h, got %h",
                 $time, what, expected, actual);
        stop_run();
    end
endtask

task automatic check_credit(input int actual, input int expected, input string what);
    if (actual != expected)
    begin
        $display("CHECK FAILED at %0t ns: %s, expected %0d, got %0d",
                 $time, what, expected, actual);
        stop_run();
    end
endtask

`endif

//--- sim/tb_gcm_tag_unit.sv
`timescale 1ns/10ps

module tb_gcm_tag_unit;

    import gcm_tag_pkg::*;

    localparam int NUM_CMDS     = 3000;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CMDS   = 300;     // No key update before this command
    localparam int HOLD_START   = 1500;    // Downstream credits withheld in this window
    localparam int HOLD_END     = 1600;
    localparam int CREDIT_TAIL  = 2;       // Last credit pulse trails the last tag

    logic       i_clock;
    logic       i_reset;
    logic       i_cmd_valid;
    cmd_op_e    i_cmd_op;
    tag_block_t i_cmd_data;
    logic       i_tag_credit;
    logic       o_cmd_credit;
    logic       o_tag_valid;
    tag_block_t o_tag;

    int seed = 19203;
    int up_credits;      // Upstream credits held by the testbench
    int dn_owed;         // Tags consumed whose credit has not gone back yet
    int dn_granted;      // Initial pool plus every credit returned
    int tags_seen;
    int credits_back;
    int cmd_index;

    gcm_tag_unit UUT
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_data   (i_cmd_data),
        .i_tag_credit (i_tag_credit),
        .o_cmd_credit (o_cmd_credit),
        .o_tag_valid  (o_tag_valid),
        .o_tag        (o_tag)
    );

    initial
    begin
        i_clock = 1'b0;
    end

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    `include "gcm_tag_model.svh"

    // Upper half of the range is always a final command
    function automatic cmd_op_e pick_opcode(input logic [3:0] sel, input logic key_ok);
        cmd_op_e op;
        op = (sel >= 4'd8) ? CMD_TAG_FINAL : cmd_op_e'(sel[2:0]);
        if (op == CMD_UPDATE_KEY && !key_ok)
        begin
            op = CMD_SOP_PRE;
        end
        return op;
    endfunction

    task automatic send_command(input int index);
        int         r;
        logic       valid;
        cmd_op_e    op;
        tag_block_t data;
        r     = $random(seed);
        valid = (r[7:4] != 4'd0);    // Rare idle cycle
        op    = pick_opcode(r[3:0], index >= QUIET_CMDS);
        data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if (op == CMD_TAG_FINAL && up_credits == 0)
        begin
            op = CMD_NOP;
        end
        if (valid)
        begin
            if (op == CMD_TAG_FINAL)
            begin
                up_credits--;
            end
            apply_command(op, data);
        end
        i_cmd_valid <= valid;
        i_cmd_op    <= op;
        i_cmd_data  <= data;
    endtask

    task automatic return_credit(input logic hold);
        int r;
        r = $random(seed);
        if (!hold && dn_owed > 0 && r[1:0] != 2'd0)
        begin
            i_tag_credit <= 1'b1;
            dn_owed--;
            dn_granted++;
        end
        else
        begin
            i_tag_credit <= 1'b0;
        end
    endtask

    // Outputs read here still hold the values of the cycle just ended
    task automatic collect_outputs();
        tag_block_t expected;
        if (o_cmd_credit)
        begin
            up_credits++;
            credits_back++;
        end
        if (up_credits > TAG_FIFO_DEPTH)
        begin
            $display("More upstream credits came back than were spent at %0t ns", $time);
            stop_run();
        end
        if (o_tag_valid)
        begin
            tags_seen++;
            if (tags_seen > dn_granted)
            begin
                $display("A tag left without a downstream credit at %0t ns", $time);
                stop_run();
            end
            if (exp_tags.size() == 0)
            begin
                $display("A tag appeared with no final command pending at %0t ns", $time);
                stop_run();
            end
            expected = exp_tags.pop_front();
            check_tag(o_tag, expected, "masked tag in command order");
            dn_owed++;
        end
    endtask

    initial
    begin
        i_reset      <= 1'b1;
        i_cmd_valid  <= 1'b0;
        i_cmd_op     <= CMD_NOP;
        i_cmd_data   <= '0;
        i_tag_credit <= 1'b0;
        up_credits   = TAG_FIFO_DEPTH;
        dn_owed      = 0;
        dn_granted   = TAG_FIFO_DEPTH;
        tags_seen    = 0;
        credits_back = 0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        for (cmd_index = 0; cmd_index < NUM_CMDS; cmd_index++)
        begin
            @(posedge i_clock);
            collect_outputs();
            if (cmd_index == HOLD_END)
            begin
                // Queue full and upstream starved while downstream is stalled
                check_credit(up_credits, 0, "upstream credits during downstream stall");
                check_credit(exp_tags.size(), TAG_FIFO_DEPTH, "tags held during stall");
            end
            send_command(cmd_index);
            return_credit(cmd_index >= HOLD_START && cmd_index < HOLD_END);
        end
        while (exp_tags.size() != 0)
        begin
            @(posedge i_clock);
            collect_outputs();
            i_cmd_valid <= 1'b0;
            return_credit(1'b0);
        end
        repeat (CREDIT_TAIL)
        begin
            @(posedge i_clock);
            collect_outputs();
            return_credit(1'b0);
        end
        check_credit(credits_back, tags_seen, "upstream credits returned per tag");
        check_credit(up_credits, TAG_FIFO_DEPTH, "upstream credits after drain");
        if (states_covered())
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Some lock state never masked a tag during the run");
            $display("Verification failed");
            $fatal(1, "Lock state coverage incomplete");
        end
    end

    // Twenty cycles per command is far beyond any credit stall
    initial
    begin
        #(NUM_CMDS * 20 * CLK_PERIOD);
        $display("Run timed out before all tags were delivered");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- gcm_tag_unit.f
+incdir+sim
design/gcm_tag_pkg.sv
design/gcm_cmd_decoder.sv
design/j0_tag_fsm.sv
design/gcm_tag_finalizer.sv
design/gcm_tag_unit.sv
sim/tb_gcm_tag_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_gcm_tag_unit
FILELIST  = gcm_tag_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: sim clean

# Build and run, then look for the pass line in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
